/* hdl/rr_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter over NumIn valid/ready inputs of any payload type
// Grant stays locked until the selected input is accepted downstream
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rr_arbiter #(
  parameter int unsigned NumIn = 4,
  parameter type payload_t = logic
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic     [NumIn-1:0]  req_valid_i,
  input  payload_t [NumIn-1:0]  req_data_i,
  output logic     [NumIn-1:0]  req_ready_o,
  output logic                  out_valid_o,
  output payload_t              out_data_o,
  input  logic                  out_ready_i
);

  typedef logic [$clog2(NumIn)-1:0] ptr_t;

  ptr_t             ptr_q, ptr_d;
  logic [NumIn-1:0] sel_gnt, gnt, gnt_q;
  logic             lock_q;

  // First valid input at or after the pointer
  always_comb begin
    int unsigned idx;
    sel_gnt = '0;
    for (int unsigned k = 0; k < NumIn; k++) begin
      idx = ptr_q + k;
      if (idx >= NumIn) begin
        idx = idx - NumIn;
      end
      if (sel_gnt == '0 && req_valid_i[idx]) begin
        sel_gnt[idx] = 1'b1;
      end
    end
  end

  assign gnt         = lock_q ? gnt_q : sel_gnt;
  assign out_valid_o = |(gnt & req_valid_i);
  assign req_ready_o = gnt & {NumIn{out_ready_i}};

  // Output mux and next pointer just past the winner
  always_comb begin
    out_data_o = req_data_i[0];
    ptr_d      = ptr_q;
    for (int unsigned i = 0; i < NumIn; i++) begin
      if (gnt[i]) begin
        out_data_o = req_data_i[i];
        ptr_d      = (i == NumIn - 1) ? '0 : ptr_t'(i + 1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q  <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else if (out_valid_o && out_ready_i) begin
      ptr_q  <= ptr_d;
      lock_q <= 1'b0;
    end else if (out_valid_o) begin
      gnt_q  <= gnt;
      lock_q <= 1'b1;
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt));

endmodule

/* hdl/spill_reg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Two-entry valid/ready buffer that breaks the ready path
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  payload_t main_q, spill_q;
  logic     main_full_q, spill_full_q;
  logic     accept, drain;

  // Ready only depends on the spill slot, so it is a flop output
  assign in_ready_o  = ~spill_full_q;
  assign out_valid_o = main_full_q;
  assign out_data_o  = main_q;

  assign accept = in_valid_i & in_ready_o;
  assign drain  = main_full_q & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      main_full_q  <= 1'b0;
      spill_full_q <= 1'b0;
    end else if (drain) begin
      main_full_q  <= spill_full_q | accept;
      spill_full_q <= 1'b0;
    end else if (accept) begin
      main_full_q  <= 1'b1;
      spill_full_q <= main_full_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (drain) begin
      main_q <= spill_full_q ? spill_q : in_data_i;
    end else if (accept && !main_full_q) begin
      main_q <= in_data_i;
    end
    if (accept && main_full_q && !drain) begin
      spill_q <= in_data_i;
    end
  end

  a_out_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

/* hdl/tcdm_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Single-port word memory with byte enables and one response slot
// Writes return the merged word, reads the stored one
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tcdm_bank
  import tcdm_group_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  bank_req_t  req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output bank_resp_t resp_o,
  output logic       resp_valid_o,
  input  logic       resp_ready_i
);

  data_t      mem_q [BankDepth];
  data_t      stored, merged;
  bank_resp_t resp_q;
  logic       resp_valid_q;
  logic       accept;

  // Slot frees up in the same cycle it drains
  assign req_ready_o = ~resp_valid_q | resp_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  always_comb begin
    stored = mem_q[req_i.tgt_addr];
    merged = stored;
    for (int unsigned i = 0; i < BeWidth; i++) begin
      if (req_i.be[i]) begin
        merged[8*i +: 8] = req_i.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && req_i.wen) begin
      mem_q[req_i.tgt_addr] <= merged;
    end
    if (accept) begin
      resp_q.ini_addr <= req_i.ini_addr;
      resp_q.rdata    <= req_i.wen ? merged : stored;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  // A stalled reply is never overwritten by a new request
  a_slot_held: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

/* hdl/tcdm_group.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Local TCDM of one group with tiles as external request ports
// Request xbar, spill registers, banks, response xbar
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tcdm_group
  import tcdm_group_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Tile request ports
  input  tcdm_req_t  [NumTiles-1:0] tile_req_i,
  input  logic       [NumTiles-1:0] tile_req_valid_i,
  output logic       [NumTiles-1:0] tile_req_ready_o,
  // Tile response ports
  output tcdm_resp_t [NumTiles-1:0] tile_resp_o,
  output logic       [NumTiles-1:0] tile_resp_valid_o,
  input  logic       [NumTiles-1:0] tile_resp_ready_i
);

  // Xbar side of the request spill registers
  bank_req_t  [NumBanks-1:0] xbar_req;
  logic       [NumBanks-1:0] xbar_req_valid;
  logic       [NumBanks-1:0] xbar_req_ready;
  // Bank side of the request spill registers
  bank_req_t  [NumBanks-1:0] bank_req;
  logic       [NumBanks-1:0] bank_req_valid;
  logic       [NumBanks-1:0] bank_req_ready;
  // Bank outputs
  bank_resp_t [NumBanks-1:0] bank_resp;
  logic       [NumBanks-1:0] bank_resp_valid;
  logic       [NumBanks-1:0] bank_resp_ready;
  // Xbar side of the response spill registers
  bank_resp_t [NumBanks-1:0] xbar_resp;
  logic       [NumBanks-1:0] xbar_resp_valid;
  logic       [NumBanks-1:0] xbar_resp_ready;

  tcdm_req_xbar i_req_xbar (
    .clk_i       (clk_i           ),
    .reset_i     (reset_i         ),
    .ini_req_i   (tile_req_i      ),
    .ini_valid_i (tile_req_valid_i),
    .ini_ready_o (tile_req_ready_o),
    .bank_req_o  (xbar_req        ),
    .bank_valid_o(xbar_req_valid  ),
    .bank_ready_i(xbar_req_ready  )
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    spill_reg #(.payload_t(bank_req_t)) i_req_spill (
      .clk_i      (clk_i            ),
      .reset_i    (reset_i          ),
      .in_valid_i (xbar_req_valid[b]),
      .in_ready_o (xbar_req_ready[b]),
      .in_data_i  (xbar_req[b]      ),
      .out_valid_o(bank_req_valid[b]),
      .out_ready_i(bank_req_ready[b]),
      .out_data_o (bank_req[b]      )
    );

    tcdm_bank i_bank (
      .clk_i       (clk_i             ),
      .reset_i     (reset_i           ),
      .req_i       (bank_req[b]       ),
      .req_valid_i (bank_req_valid[b] ),
      .req_ready_o (bank_req_ready[b] ),
      .resp_o      (bank_resp[b]      ),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_ready_i(bank_resp_ready[b])
    );

    spill_reg #(.payload_t(bank_resp_t)) i_resp_spill (
      .clk_i      (clk_i             ),
      .reset_i    (reset_i           ),
      .in_valid_i (bank_resp_valid[b]),
      .in_ready_o (bank_resp_ready[b]),
      .in_data_i  (bank_resp[b]      ),
      .out_valid_o(xbar_resp_valid[b]),
      .out_ready_i(xbar_resp_ready[b]),
      .out_data_o (xbar_resp[b]      )
    );
  end

  tcdm_resp_xbar i_resp_xbar (
    .clk_i       (clk_i            ),
    .reset_i     (reset_i          ),
    .bank_resp_i (xbar_resp        ),
    .bank_valid_i(xbar_resp_valid  ),
    .bank_ready_o(xbar_resp_ready  ),
    .ini_resp_o  (tile_resp_o      ),
    .ini_valid_o (tile_resp_valid_o),
    .ini_ready_i (tile_resp_ready_i)
  );

endmodule

/* hdl/tcdm_group_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Sizes, address fields and payload structs of the TCDM group
// Imported by every RTL block and by the testbench
// ~~~~~~~~~~~~~~~~~~~~

package tcdm_group_pkg;

  // Group geometry
  localparam int unsigned NumTiles      = 4;
  localparam int unsigned NumBanks      = 4;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned BeWidth       = DataWidth / 8;
  localparam int unsigned BankDepth     = 64;

  // Word address split, bank select in the low bits
  localparam int unsigned TcdmAddrWidth = 8;
  localparam int unsigned BankSelWidth  = 2;
  localparam int unsigned RowWidth      = 6;
  localparam int unsigned IniWidth      = 2;

  typedef logic [TcdmAddrWidth-1:0] tcdm_addr_t;
  typedef logic [RowWidth-1:0]      row_addr_t;
  typedef logic [IniWidth-1:0]      ini_addr_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [BeWidth-1:0]       strb_t;

  // Tile side request
  typedef struct packed {
    tcdm_addr_t tgt_addr;
    logic       wen;
    data_t      wdata;
    strb_t      be;
  } tcdm_req_t;

  // Tile side response
  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

  // Bank side request, tagged with the initiator
  typedef struct packed {
    row_addr_t tgt_addr;
    ini_addr_t ini_addr;
    logic      wen;
    data_t     wdata;
    strb_t     be;
  } bank_req_t;

  // Bank side response, tag returned for routing
  typedef struct packed {
    ini_addr_t ini_addr;
    data_t     rdata;
  } bank_resp_t;

endpackage

/* hdl/tcdm_req_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Request crossbar from tiles to banks, one arbiter per bank
// Tags each bank request with the index of the tile that sent it
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tcdm_req_xbar
  import tcdm_group_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  tcdm_req_t [NumTiles-1:0] ini_req_i,
  input  logic      [NumTiles-1:0] ini_valid_i,
  output logic      [NumTiles-1:0] ini_ready_o,
  output bank_req_t [NumBanks-1:0] bank_req_o,
  output logic      [NumBanks-1:0] bank_valid_o,
  input  logic      [NumBanks-1:0] bank_ready_i
);

  bank_req_t [NumTiles-1:0]                tagged_req;
  logic      [NumBanks-1:0][NumTiles-1:0] lane_valid;
  logic      [NumBanks-1:0][NumTiles-1:0] lane_ready;

  // Row bits plus initiator tag
  for (genvar t = 0; t < NumTiles; t++) begin : gen_tag
    assign tagged_req[t].tgt_addr = ini_req_i[t].tgt_addr[TcdmAddrWidth-1:BankSelWidth];
    assign tagged_req[t].ini_addr = ini_addr_t'(t);
    assign tagged_req[t].wen      = ini_req_i[t].wen;
    assign tagged_req[t].wdata    = ini_req_i[t].wdata;
    assign tagged_req[t].be       = ini_req_i[t].be;
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    for (genvar t = 0; t < NumTiles; t++) begin : gen_decode
      assign lane_valid[b][t] = ini_valid_i[t] &&
          (ini_req_i[t].tgt_addr[BankSelWidth-1:0] == BankSelWidth'(b));
    end

    rr_arbiter #(
      .NumIn    (NumTiles  ),
      .payload_t(bank_req_t)
    ) i_arb (
      .clk_i      (clk_i          ),
      .reset_i    (reset_i        ),
      .req_valid_i(lane_valid[b]  ),
      .req_data_i (tagged_req     ),
      .req_ready_o(lane_ready[b]  ),
      .out_valid_o(bank_valid_o[b]),
      .out_data_o (bank_req_o[b]  ),
      .out_ready_i(bank_ready_i[b])
    );
  end

  // Each tile targets one bank, so at most one lane answers
  always_comb begin
    ini_ready_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      for (int unsigned t = 0; t < NumTiles; t++) begin
        ini_ready_o[t] = ini_ready_o[t] | lane_ready[b][t];
      end
    end
  end

endmodule

/* hdl/tcdm_resp_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Response crossbar from banks back to tiles by initiator tag
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tcdm_resp_xbar
  import tcdm_group_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  bank_resp_t [NumBanks-1:0] bank_resp_i,
  input  logic       [NumBanks-1:0] bank_valid_i,
  output logic       [NumBanks-1:0] bank_ready_o,
  output tcdm_resp_t [NumTiles-1:0] ini_resp_o,
  output logic       [NumTiles-1:0] ini_valid_o,
  input  logic       [NumTiles-1:0] ini_ready_i
);

  tcdm_resp_t [NumBanks-1:0]               stripped;
  logic       [NumTiles-1:0][NumBanks-1:0] lane_valid;
  logic       [NumTiles-1:0][NumBanks-1:0] lane_ready;

  // Tag only steers, tiles see plain read data
  for (genvar b = 0; b < NumBanks; b++) begin : gen_strip
    assign stripped[b].rdata = bank_resp_i[b].rdata;
  end

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tile
    for (genvar b = 0; b < NumBanks; b++) begin : gen_decode
      assign lane_valid[t][b] = bank_valid_i[b] &&
          (bank_resp_i[b].ini_addr == ini_addr_t'(t));
    end

    rr_arbiter #(
      .NumIn    (NumBanks   ),
      .payload_t(tcdm_resp_t)
    ) i_arb (
      .clk_i      (clk_i         ),
      .reset_i    (reset_i       ),
      .req_valid_i(lane_valid[t] ),
      .req_data_i (stripped      ),
      .req_ready_o(lane_ready[t] ),
      .out_valid_o(ini_valid_o[t]),
      .out_data_o (ini_resp_o[t] ),
      .out_ready_i(ini_ready_i[t])
    );
  end

  always_comb begin
    bank_ready_o = '0;
    for (int unsigned t = 0; t < NumTiles; t++) begin
      for (int unsigned b = 0; b < NumBanks; b++) begin
        bank_ready_o[b] = bank_ready_o[b] | lane_ready[t][b];
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
  -f vlog.f --top-module tb_tcdm_group -o tb_tcdm_group &&
./obj_dir/tb_tcdm_group | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null &&
echo "Simulation passed" ||
{
  echo "Simulation failed"
  exit 1
}

/* verification/tcdm_group_vectors.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Stimulus rows and expected responses for the TCDM group testbench
// Included inside the testbench module, rows of one group launch together
// ~~~~~~~~~~~~~~~~~~~~

`ifndef TCDM_GROUP_VECTORS_SVH
`define TCDM_GROUP_VECTORS_SVH

// Columns: tile, word address, write enable, write data, byte enables,
// expected response data, group
typedef struct packed {
  logic [1:0] tile;
  tcdm_addr_t addr;
  logic       wen;
  data_t      wdata;
  strb_t      be;
  data_t      exp_rdata;
  logic [4:0] grp;
} vec_t;

localparam int NumVecs    = 44;
localparam int NumGroups  = 20;
// Groups from here on run with random response stalls
localparam int StallGroup = 16;

localparam vec_t Vectors [NumVecs] = '{
  // Full write then read, one bank at a time from tile 0
  '{2'd0, 8'h04, 1'b1, 32'h11223344, 4'hf, 32'h11223344, 5'd0},
  '{2'd0, 8'h04, 1'b0, 32'h00000000, 4'h0, 32'h11223344, 5'd1},
  '{2'd0, 8'h25, 1'b1, 32'hA5A50F0F, 4'hf, 32'hA5A50F0F, 5'd2},
  '{2'd0, 8'h25, 1'b0, 32'h00000000, 4'h0, 32'hA5A50F0F, 5'd3},
  '{2'd0, 8'h4A, 1'b1, 32'hDEADBEEF, 4'hf, 32'hDEADBEEF, 5'd4},
  '{2'd0, 8'h4A, 1'b0, 32'h00000000, 4'h0, 32'hDEADBEEF, 5'd5},
  '{2'd0, 8'hFF, 1'b1, 32'h0BADF00D, 4'hf, 32'h0BADF00D, 5'd6},
  '{2'd0, 8'hFF, 1'b0, 32'h00000000, 4'h0, 32'h0BADF00D, 5'd7},
  // Partial byte enables merged over older words
  '{2'd2, 8'h04, 1'b1, 32'hCAFEBABE, 4'hc, 32'hCAFE3344, 5'd8},
  '{2'd2, 8'h04, 1'b0, 32'h00000000, 4'h0, 32'hCAFE3344, 5'd9},
  '{2'd2, 8'h25, 1'b1, 32'h12345678, 4'h5, 32'hA5340F78, 5'd10},
  '{2'd2, 8'h25, 1'b0, 32'h00000000, 4'h0, 32'hA5340F78, 5'd11},
  // All tiles into bank 2 at once
  '{2'd0, 8'h02, 1'b1, 32'h00000002, 4'hf, 32'h00000002, 5'd12},
  '{2'd1, 8'h06, 1'b1, 32'h10000006, 4'hf, 32'h10000006, 5'd12},
  '{2'd2, 8'h0A, 1'b1, 32'h2000000A, 4'hf, 32'h2000000A, 5'd12},
  '{2'd3, 8'h0E, 1'b1, 32'h3000000E, 4'hf, 32'h3000000E, 5'd12},
  '{2'd0, 8'h0E, 1'b0, 32'h00000000, 4'h0, 32'h3000000E, 5'd13},
  '{2'd1, 8'h0A, 1'b0, 32'h00000000, 4'h0, 32'h2000000A, 5'd13},
  '{2'd2, 8'h06, 1'b0, 32'h00000000, 4'h0, 32'h10000006, 5'd13},
  '{2'd3, 8'h02, 1'b0, 32'h00000000, 4'h0, 32'h00000002, 5'd13},
  // One tile per bank
  '{2'd0, 8'h04, 1'b0, 32'h00000000, 4'h0, 32'hCAFE3344, 5'd14},
  '{2'd1, 8'h31, 1'b1, 32'h5555AAAA, 4'hf, 32'h5555AAAA, 5'd14},
  '{2'd2, 8'h4A, 1'b0, 32'h00000000, 4'h0, 32'hDEADBEEF, 5'd14},
  '{2'd3, 8'h13, 1'b1, 32'h76543210, 4'hf, 32'h76543210, 5'd14},
  '{2'd0, 8'h13, 1'b0, 32'h00000000, 4'h0, 32'h76543210, 5'd15},
  '{2'd1, 8'h25, 1'b0, 32'h00000000, 4'h0, 32'hA5340F78, 5'd15},
  '{2'd2, 8'h0A, 1'b0, 32'h00000000, 4'h0, 32'h2000000A, 5'd15},
  '{2'd3, 8'h04, 1'b0, 32'h00000000, 4'h0, 32'hCAFE3344, 5'd15},
  // Mixed traffic under response stalls
  '{2'd0, 8'h4A, 1'b1, 32'h00001234, 4'h3, 32'hDEAD1234, 5'd16},
  '{2'd1, 8'h02, 1'b1, 32'h7F000000, 4'h8, 32'h7F000002, 5'd16},
  '{2'd2, 8'h06, 1'b1, 32'h66666666, 4'hf, 32'h66666666, 5'd16},
  '{2'd3, 8'hFF, 1'b1, 32'h000000EE, 4'h1, 32'h0BADF0EE, 5'd16},
  '{2'd0, 8'hFF, 1'b0, 32'h00000000, 4'h0, 32'h0BADF0EE, 5'd17},
  '{2'd1, 8'h4A, 1'b0, 32'h00000000, 4'h0, 32'hDEAD1234, 5'd17},
  '{2'd2, 8'h02, 1'b0, 32'h00000000, 4'h0, 32'h7F000002, 5'd17},
  '{2'd3, 8'h06, 1'b0, 32'h00000000, 4'h0, 32'h66666666, 5'd17},
  '{2'd0, 8'h31, 1'b0, 32'h00000000, 4'h0, 32'h5555AAAA, 5'd18},
  '{2'd1, 8'h13, 1'b0, 32'h00000000, 4'h0, 32'h76543210, 5'd18},
  '{2'd2, 8'h25, 1'b0, 32'h00000000, 4'h0, 32'hA5340F78, 5'd18},
  '{2'd3, 8'h0E, 1'b0, 32'h00000000, 4'h0, 32'h3000000E, 5'd18},
  '{2'd0, 8'h02, 1'b0, 32'h00000000, 4'h0, 32'h7F000002, 5'd19},
  '{2'd1, 8'h06, 1'b0, 32'h00000000, 4'h0, 32'h66666666, 5'd19},
  '{2'd2, 8'h0A, 1'b0, 32'h00000000, 4'h0, 32'h2000000A, 5'd19},
  '{2'd3, 8'h0E, 1'b0, 32'h00000000, 4'h0, 32'h3000000E, 5'd19}
};

`endif

/* verification/tb_tcdm_group.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the TCDM group, runs the vector table group by group
// Checks responses against its own memory model and prints the result
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_tcdm_group
  import tcdm_group_pkg::*;
();

  `include "tcdm_group_vectors.svh"

  localparam int unsigned TimeoutCycles = NumVecs * 40;

  logic                      clk_i;
  logic                      reset_i;
  tcdm_req_t  [NumTiles-1:0] tile_req_i;
  logic       [NumTiles-1:0] tile_req_valid_i;
  logic       [NumTiles-1:0] tile_req_ready_o;
  tcdm_resp_t [NumTiles-1:0] tile_resp_o;
  logic       [NumTiles-1:0] tile_resp_valid_o;
  logic       [NumTiles-1:0] tile_resp_ready_i;

  // Reference memory, indexed by tile word address
  data_t       ref_mem [2**TcdmAddrWidth];
  data_t       exp_data [NumTiles];
  logic        in_flight [NumTiles];
  logic        held [NumTiles];
  tcdm_resp_t  held_resp [NumTiles];
  integer      seed;
  int unsigned cycle_count = 0;
  int unsigned remaining;
  int unsigned peak;
  int          checks = 0;
  int          errors = 0;

  tcdm_group dut (
    .clk_i            (clk_i            ),
    .reset_i          (reset_i          ),
    .tile_req_i       (tile_req_i       ),
    .tile_req_valid_i (tile_req_valid_i ),
    .tile_req_ready_o (tile_req_ready_o ),
    .tile_resp_o      (tile_resp_o      ),
    .tile_resp_valid_o(tile_resp_valid_o),
    .tile_resp_ready_i(tile_resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #50 clk_i = ~clk_i;

  // Watchdog for a lost response or a stuck request
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, not every response came back", cycle_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t be);
    data_t word;
    word = old_word;
    for (int unsigned i = 0; i < BeWidth; i++) begin
      if (be[i]) begin
        word[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return word;
  endfunction

  function automatic string group_name(int g);
    if (g < 8) return "write then read per bank";
    if (g < 12) return "partial byte enables";
    if (g < 14) return "same bank contention";
    if (g < StallGroup) return "one tile per bank";
    return "response back-pressure";
  endfunction

  task automatic check_reset_state();
    @(posedge clk_i);
    checks++;
    assert (tile_resp_valid_o == '0) else begin
      errors++;
      $display("[ERROR] tile_resp_valid_o after reset: expected %h, got %h",
               {NumTiles{1'b0}}, tile_resp_valid_o);
    end
    $display("Test reset: done, %0d errors so far", errors);
  endtask

  // One clock edge of monitoring and driving, values sampled before the edge updates
  task automatic step_cycle(input logic stall_en, input int unsigned waited);
    logic [31:0] rnd;
    int unsigned cur;
    for (int unsigned t = 0; t < NumTiles; t++) begin
      if (held[t]) begin
        checks++;
        assert (tile_resp_valid_o[t]) else begin
          errors++;
          $display("Tile %0d dropped its response valid before it was accepted", t);
        end
        checks++;
        assert (tile_resp_o[t] == held_resp[t]) else begin
          errors++;
          $display("[ERROR] tile_resp_o[%0d] while stalled: expected %h, got %h",
                   t, held_resp[t], tile_resp_o[t]);
        end
      end
      held[t]      = tile_resp_valid_o[t] && !tile_resp_ready_i[t];
      held_resp[t] = tile_resp_o[t];

      if (tile_resp_valid_o[t] && tile_resp_ready_i[t]) begin
        checks++;
        assert (in_flight[t]) else begin
          errors++;
          $display("Tile %0d got a response with no request in flight", t);
        end
        if (in_flight[t]) begin
          checks++;
          assert (tile_resp_o[t].rdata === exp_data[t]) else begin
            errors++;
            $display("[ERROR] tile_resp_o[%0d].rdata: expected %h, got %h",
                     t, exp_data[t], tile_resp_o[t].rdata);
          end
          in_flight[t] = 1'b0;
          remaining--;
        end
      end

      if (tile_req_valid_i[t] && tile_req_ready_o[t]) begin
        tile_req_valid_i[t] <= 1'b0;
        in_flight[t] = 1'b1;
        checks++;
        assert (waited <= NumTiles) else begin
          errors++;
          $display("Tile %0d waited %0d cycles for its request to be granted", t, waited);
        end
      end

      rnd = $random(seed);
      tile_resp_ready_i[t] <= stall_en ? (rnd[1:0] != 2'b00) : 1'b1;
    end

    cur = 0;
    for (int unsigned t = 0; t < NumTiles; t++) begin
      if (in_flight[t]) begin
        cur++;
      end
    end
    if (cur > peak) begin
      peak = cur;
    end
  endtask

  task automatic run_group(input int g);
    vec_t        v;
    data_t       expv;
    int unsigned rows;
    int unsigned waited;
    logic        stall_en;
    rows     = 0;
    waited   = 0;
    peak     = 0;
    stall_en = (g >= StallGroup);
    for (int i = 0; i < NumVecs; i++) begin
      v = Vectors[i];
      if (int'(v.grp) == g) begin
        expv = v.wen ? merge_bytes(ref_mem[v.addr], v.wdata, v.be) : ref_mem[v.addr];
        if (v.wen) begin
          ref_mem[v.addr] = expv;
        end
        checks++;
        assert (expv === v.exp_rdata) else begin
          errors++;
          $display("[ERROR] row %0d exp_rdata: model %h, table %h", i, expv, v.exp_rdata);
        end
        exp_data[v.tile] = expv;
        tile_req_i[v.tile]       <= '{tgt_addr: v.addr, wen: v.wen, wdata: v.wdata, be: v.be};
        tile_req_valid_i[v.tile] <= 1'b1;
        rows++;
      end
    end
    remaining = rows;
    while (remaining != 0) begin
      @(posedge clk_i);
      waited++;
      step_cycle(stall_en, waited);
    end
    tile_resp_ready_i <= '1;
    if (rows > 1) begin
      checks++;
      assert (peak > 1) else begin
        errors++;
        $display("Group %0d never had more than one request in flight", g);
      end
    end
    $display("Test group %0d (%s): %0d rows, peak %0d in flight, %0d errors so far",
             g, group_name(g), rows, peak, errors);
  endtask

  initial begin
    seed              = 32'h538f2c9e;
    reset_i           = 1'b1;
    tile_req_i        = '0;
    tile_req_valid_i  = '0;
    tile_resp_ready_i = '1;
    for (int unsigned t = 0; t < NumTiles; t++) begin
      in_flight[t] = 1'b0;
      held[t]      = 1'b0;
    end

    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    check_reset_state();

    for (int g = 0; g < NumGroups; g++) begin
      run_group(g);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+verification
hdl/tcdm_group_pkg.sv
hdl/rr_arbiter.sv
hdl/spill_reg.sv
hdl/tcdm_bank.sv
hdl/tcdm_req_xbar.sv
hdl/tcdm_resp_xbar.sv
hdl/tcdm_group.sv
verification/tb_tcdm_group.sv
